//--- hw/atari_io_consts.svh
`ifndef ATARI_IO_CONSTS_SVH
`define ATARI_IO_CONSTS_SVH

// Virtual disk units and the shared sector buffer
`define DISK_UNITS     7
`define SECTOR_BYTES   512
`define BUF_ADDR_W     9

// Data path widths
`define BYTE_W         8
`define LBA_W          32
`define UNIT_NUM_W     3
`define FILE_TYPE_W    2

// Mouse to paddle emulation
`define MOUSE_DELTA_W  9
`define AXIS_W         8
`define MOUSE_STEP_MAX 10

// Cartridge and executable slots, never writable
`define UNIT_RO_A      4
`define UNIT_RO_B      5

`endif

//--- hw/atari_io_pkg.sv
`include "atari_io_consts.svh"

package atari_io_pkg;

	// One data byte of the sector buffer
	typedef logic [`BYTE_W-1:0] byte_t;

	// Byte position inside one sector
	typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;

	// Block address, also used for the image file size
	typedef logic [`LBA_W-1:0] lba_t;

	// One bit per virtual disk unit
	typedef logic [`DISK_UNITS-1:0] unit_mask_t;

	typedef logic [`UNIT_NUM_W-1:0] unit_num_t;

	// Image type code as reported by the host
	typedef logic [`FILE_TYPE_W-1:0] file_type_t;

	// Relative mouse motion, two's complement
	typedef logic signed [`MOUSE_DELTA_W-1:0] mouse_delta_t;

	// Paddle position, centred on zero
	typedef logic signed [`AXIS_W-1:0] axis_t;

endpackage

//--- hw/sector_buffer.sv
`include "atari_io_consts.svh"

module sector_buffer (
	input  logic                    clk_sys,

	// Host side
	input  atari_io_pkg::buf_addr_t a_addr_i,
	input  atari_io_pkg::byte_t     a_data_i,
	input  logic                    a_we_i,
	output atari_io_pkg::byte_t     a_q_o,

	// Controller side
	input  atari_io_pkg::buf_addr_t b_addr_i,
	input  atari_io_pkg::byte_t     b_data_i,
	input  logic                    b_we_i,
	output atari_io_pkg::byte_t     b_q_o
);
	import atari_io_pkg::*;

	byte_t mem [0:`SECTOR_BYTES-1];

	// Both ports write and read in the same clock domain.
	// Reads return the old contents when a port writes its own address
	always_ff @(posedge clk_sys) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_data_i;
		end
		if (b_we_i) begin
			mem[b_addr_i] <= b_data_i;
		end
		a_q_o <= mem[a_addr_i];
		b_q_o <= mem[b_addr_i];
	end

endmodule

//--- hw/disk_bridge.sv
`include "atari_io_consts.svh"

module disk_bridge (
	input  logic                       clk_sys,
	input  logic                       areset,

	// Controller registers and strobes
	input  logic                       lba_sel_i,
	input  logic                       block_rd_i,
	input  logic                       block_wr_i,
	input  atari_io_pkg::unit_num_t    drv_num_i,
	input  atari_io_pkg::lba_t         data_i,
	input  logic                       io_wr_i,
	input  logic                       data_wr_i,
	input  logic                       data_rd_i,
	output atari_io_pkg::lba_t         data_o,
	output logic                       io_done_o,

	// Host block service
	output atari_io_pkg::unit_mask_t   sd_rd_o,
	output atari_io_pkg::unit_mask_t   sd_wr_o,
	output atari_io_pkg::lba_t         sd_lba_o,
	input  atari_io_pkg::unit_mask_t   sd_ack_i,

	// Image mount
	input  atari_io_pkg::unit_mask_t   img_mounted_i,
	input  logic                       img_readonly_i,
	input  atari_io_pkg::lba_t         img_size_i,
	input  atari_io_pkg::file_type_t   file_type_i,
	output logic                       mount_toggle_o,
	output atari_io_pkg::unit_num_t    file_no_o,
	output atari_io_pkg::file_type_t   file_type_o,
	output logic                       readonly_o,

	// Controller port of the sector buffer
	output atari_io_pkg::buf_addr_t    buf_addr_o,
	output atari_io_pkg::byte_t        buf_data_o,
	output logic                       buf_we_o,
	input  atari_io_pkg::byte_t        buf_q_i
);
	import atari_io_pkg::*;

	// Two-deep history of each strobe, newest in bit 0
	logic [1:0] wr_hist;
	logic [1:0] blrd_hist;
	logic [1:0] blwr_hist;
	logic [1:0] mnt_hist;
	logic       rd_last;
	logic       ack_last;
	logic       lba_we_q;
	logic       lba_sel_q;
	lba_t       wr_data_q;
	lba_t       file_size_q;
	unit_mask_t mnt_units_q;
	logic       mnt_ro_q;
	lba_t       mnt_size_q;
	file_type_t mnt_type_q;
	logic       wr_rise;
	logic       blrd_rise;
	logic       blwr_rise;
	logic       mnt_rise;
	logic       rd_fall;
	logic       ack_fall;

	assign wr_rise   = wr_hist[0] & ~wr_hist[1];
	assign blrd_rise = blrd_hist[0] & ~blrd_hist[1];
	assign blwr_rise = blwr_hist[0] & ~blwr_hist[1];
	assign mnt_rise  = mnt_hist[0] & ~mnt_hist[1];
	assign rd_fall   = rd_last & ~data_rd_i;
	assign ack_fall  = ack_last & ~(|sd_ack_i);

	assign buf_data_o = wr_data_q[`BYTE_W-1:0];

	// ========================================================================
	// Strobes, buffer pointer and block requests
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_hist        <= '0;
			blrd_hist      <= '0;
			blwr_hist      <= '0;
			mnt_hist       <= '0;
			rd_last        <= 1'b0;
			ack_last       <= 1'b0;
			buf_we_o       <= 1'b0;
			lba_we_q       <= 1'b0;
			buf_addr_o     <= '0;
			sd_rd_o        <= '0;
			sd_wr_o        <= '0;
			io_done_o      <= 1'b0;
			mount_toggle_o <= 1'b0;
		end else begin
			wr_hist   <= {wr_hist[0], data_wr_i};
			blrd_hist <= {blrd_hist[0], block_rd_i};
			blwr_hist <= {blwr_hist[0], block_wr_i};
			mnt_hist  <= {mnt_hist[0], |img_mounted_i};
			rd_last   <= data_rd_i;
			ack_last  <= |sd_ack_i;

			// A data write goes either to the block address or to the buffer
			buf_we_o <= wr_rise & ~lba_sel_i;
			lba_we_q <= wr_rise & lba_sel_i;

			if (buf_we_o || rd_fall) begin
				buf_addr_o <= buf_addr_o + 1'b1;
			end
			if (io_wr_i) begin
				buf_addr_o <= '0;
			end

			if (blrd_rise) begin
				sd_rd_o[drv_num_i] <= 1'b1;
				io_done_o          <= 1'b0;
			end
			if (blwr_rise) begin
				sd_wr_o[drv_num_i] <= 1'b1;
				io_done_o          <= 1'b0;
			end

			// Host has taken the request
			if (|sd_ack_i) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end
			if (ack_fall) begin
				io_done_o <= 1'b1;
			end

			if (mnt_rise) begin
				mount_toggle_o <= ~mount_toggle_o;
			end
		end
	end

	// ========================================================================
	// Block address, mount details and read-back
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			wr_data_q <= data_i;
		end
		if (lba_we_q) begin
			sd_lba_o <= wr_data_q;
		end

		// Mount info is only valid while the pulse is high
		if (|img_mounted_i) begin
			mnt_units_q <= img_mounted_i;
			mnt_ro_q    <= img_readonly_i;
			mnt_size_q  <= img_size_i;
			mnt_type_q  <= file_type_i;
		end

		if (mnt_rise) begin
			// Highest mounted unit wins
			for (int i = 0; i < `DISK_UNITS; i++) begin
				if (mnt_units_q[i]) begin
					file_no_o <= unit_num_t'(i);
				end
			end
			file_type_o <= mnt_type_q;
			readonly_o  <= mnt_ro_q | mnt_units_q[`UNIT_RO_A] | mnt_units_q[`UNIT_RO_B];
			file_size_q <= mnt_size_q;
		end

		lba_sel_q <= lba_sel_i;
		data_o    <= lba_sel_q ? file_size_q : lba_t'(buf_q_i);
	end

endmodule

//--- hw/mouse_axis.sv
`include "atari_io_consts.svh"

module mouse_axis (
	input  logic                       clk_sys,
	input  logic                       areset,

	// Mouse packets, one toggle of the strobe per packet
	input  logic                       mouse_stb_i,
	input  atari_io_pkg::mouse_delta_t mouse_dx_i,
	input  atari_io_pkg::mouse_delta_t mouse_dy_i,
	input  logic [1:0]                 mouse_btn_i,
	input  logic                       invert_y_i,
	input  logic                       cpu_halt_i,

	// Analog stick
	input  atari_io_pkg::axis_t        stick_x_i,
	input  atari_io_pkg::axis_t        stick_y_i,
	input  logic [1:0]                 stick_btn_i,

	output atari_io_pkg::axis_t        paddle_x_o,
	output atari_io_pkg::axis_t        paddle_y_o,
	output logic [1:0]                 paddle_btn_o,
	output logic                       mouse_mode_o
);
	import atari_io_pkg::*;

	localparam int STEP_MAX = `MOUSE_STEP_MAX;
	localparam int AXIS_MAX = (1 << (`AXIS_W - 1)) - 1;
	localparam int AXIS_MIN = -(1 << (`AXIS_W - 1));

	logic [1:0] stb_hist;
	axis_t      pos_x;
	axis_t      pos_y;
	logic       stick_moved;

	// Limit one motion step to +/- STEP_MAX
	function automatic logic signed [9:0] clamp_step(input mouse_delta_t d);
		logic signed [9:0] wide;
		wide = d;
		if (wide > STEP_MAX) begin
			return 10'(STEP_MAX);
		end
		if (wide < -STEP_MAX) begin
			return 10'(-STEP_MAX);
		end
		return wide;
	endfunction

	// Move the position by one step, pinned at the axis limits
	function automatic axis_t sat_move(input axis_t pos, input logic signed [9:0] step,
		input logic neg);
		logic signed [9:0] sum;
		if (neg) begin
			sum = pos - step;
		end else begin
			sum = pos + step;
		end
		if (sum > AXIS_MAX) begin
			return axis_t'(AXIS_MAX);
		end
		if (sum < AXIS_MIN) begin
			return axis_t'(AXIS_MIN);
		end
		return sum[`AXIS_W-1:0];
	endfunction

	assign stick_moved = (stick_x_i != '0) || (stick_y_i != '0);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_hist     <= '0;
			mouse_mode_o <= 1'b0;
			pos_x        <= '0;
			pos_y        <= '0;
		end else begin
			stb_hist <= {stb_hist[0], mouse_stb_i};
			if (stb_hist[0] != stb_hist[1]) begin
				mouse_mode_o <= 1'b1;
				pos_x        <= sat_move(pos_x, clamp_step(mouse_dx_i), 1'b0);
				pos_y        <= sat_move(pos_y, clamp_step(mouse_dy_i), invert_y_i);
			end
			// Stick or halted CPU hands control back to the stick
			if (stick_moved || cpu_halt_i) begin
				mouse_mode_o <= 1'b0;
				pos_x        <= '0;
				pos_y        <= '0;
			end
		end
	end

	assign paddle_x_o   = mouse_mode_o ? pos_x : stick_x_i;
	assign paddle_y_o   = mouse_mode_o ? pos_y : stick_y_i;
	assign paddle_btn_o = mouse_mode_o ? mouse_btn_i : stick_btn_i;

endmodule

//--- hw/atari_io_top.sv
module atari_io_top (
	input  logic                       clk_sys,
	input  logic                       areset,

	// Controller
	input  logic                       lba_sel_i,
	input  logic                       block_rd_i,
	input  logic                       block_wr_i,
	input  atari_io_pkg::unit_num_t    drv_num_i,
	input  atari_io_pkg::lba_t         data_i,
	input  logic                       io_wr_i,
	input  logic                       data_wr_i,
	input  logic                       data_rd_i,
	output atari_io_pkg::lba_t         data_o,
	output logic                       io_done_o,

	// Host block service
	output atari_io_pkg::unit_mask_t   sd_rd_o,
	output atari_io_pkg::unit_mask_t   sd_wr_o,
	output atari_io_pkg::lba_t         sd_lba_o,
	input  atari_io_pkg::unit_mask_t   sd_ack_i,
	input  atari_io_pkg::buf_addr_t    sd_buff_addr_i,
	input  atari_io_pkg::byte_t        sd_buff_dout_i,
	input  logic                       sd_buff_wr_i,
	output atari_io_pkg::byte_t        sd_buff_din_o,

	// Image mount
	input  atari_io_pkg::unit_mask_t   img_mounted_i,
	input  logic                       img_readonly_i,
	input  atari_io_pkg::lba_t         img_size_i,
	input  atari_io_pkg::file_type_t   file_type_i,
	output logic                       mount_toggle_o,
	output atari_io_pkg::unit_num_t    file_no_o,
	output atari_io_pkg::file_type_t   file_type_o,
	output logic                       readonly_o,

	// Mouse and stick
	input  logic                       mouse_stb_i,
	input  atari_io_pkg::mouse_delta_t mouse_dx_i,
	input  atari_io_pkg::mouse_delta_t mouse_dy_i,
	input  logic [1:0]                 mouse_btn_i,
	input  logic                       invert_y_i,
	input  logic                       cpu_halt_i,
	input  atari_io_pkg::axis_t        stick_x_i,
	input  atari_io_pkg::axis_t        stick_y_i,
	input  logic [1:0]                 stick_btn_i,
	output atari_io_pkg::axis_t        paddle_x_o,
	output atari_io_pkg::axis_t        paddle_y_o,
	output logic [1:0]                 paddle_btn_o,
	output logic                       mouse_mode_o
);
	import atari_io_pkg::*;

	// Controller port of the sector buffer
	buf_addr_t buf_addr;
	byte_t     buf_data;
	logic      buf_we;
	byte_t     buf_q;

	disk_bridge bridge0 (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.lba_sel_i      (lba_sel_i),
		.block_rd_i     (block_rd_i),
		.block_wr_i     (block_wr_i),
		.drv_num_i      (drv_num_i),
		.data_i         (data_i),
		.io_wr_i        (io_wr_i),
		.data_wr_i      (data_wr_i),
		.data_rd_i      (data_rd_i),
		.data_o         (data_o),
		.io_done_o      (io_done_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_lba_o       (sd_lba_o),
		.sd_ack_i       (sd_ack_i),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.file_type_i    (file_type_i),
		.mount_toggle_o (mount_toggle_o),
		.file_no_o      (file_no_o),
		.file_type_o    (file_type_o),
		.readonly_o     (readonly_o),
		.buf_addr_o     (buf_addr),
		.buf_data_o     (buf_data),
		.buf_we_o       (buf_we),
		.buf_q_i        (buf_q)
	);

	// Port A belongs to the host, port B to the controller
	sector_buffer sbuf0 (
		.clk_sys  (clk_sys),
		.a_addr_i (sd_buff_addr_i),
		.a_data_i (sd_buff_dout_i),
		.a_we_i   (sd_buff_wr_i),
		.a_q_o    (sd_buff_din_o),
		.b_addr_i (buf_addr),
		.b_data_i (buf_data),
		.b_we_i   (buf_we),
		.b_q_o    (buf_q)
	);

	mouse_axis mouse0 (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.mouse_stb_i  (mouse_stb_i),
		.mouse_dx_i   (mouse_dx_i),
		.mouse_dy_i   (mouse_dy_i),
		.mouse_btn_i  (mouse_btn_i),
		.invert_y_i   (invert_y_i),
		.cpu_halt_i   (cpu_halt_i),
		.stick_x_i    (stick_x_i),
		.stick_y_i    (stick_y_i),
		.stick_btn_i  (stick_btn_i),
		.paddle_x_o   (paddle_x_o),
		.paddle_y_o   (paddle_y_o),
		.paddle_btn_o (paddle_btn_o),
		.mouse_mode_o (mouse_mode_o)
	);

endmodule

//--- verification/atari_io_props.sv
module atari_io_props (
	input logic                     clk_sys,
	input logic                     areset,
	input atari_io_pkg::unit_mask_t req_rd_i,
	input atari_io_pkg::unit_mask_t req_wr_i,
	input atari_io_pkg::unit_mask_t ack_i,
	input atari_io_pkg::unit_mask_t mounted_i,
	input logic                     toggle_i
);

	logic mount_any;

	assign mount_any = |mounted_i;

	// One unit at a time, and never a read and a write together
	req_onehot: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0(req_rd_i) && $onehot0(req_wr_i) && !((|req_rd_i) && (|req_wr_i)))
		else $error("more than one block request is active");

	// Any acknowledge clears every request at the next edge
	req_clear: assert property (@(posedge clk_sys) disable iff (areset)
		(|ack_i) |=> (req_rd_i == '0) && (req_wr_i == '0))
		else $error("block request still set after an acknowledge");

	// Toggle moves only two cycles after a mount pulse starts
	mount_flip: assert property (@(posedge clk_sys) disable iff (areset)
		$changed(toggle_i) |-> $past(mount_any, 2) && !$past(mount_any, 3))
		else $error("mount toggle changed without a mount pulse");

endmodule

bind disk_bridge atari_io_props props0 (
	.clk_sys   (clk_sys),
	.areset    (areset),
	.req_rd_i  (sd_rd_o),
	.req_wr_i  (sd_wr_o),
	.ack_i     (sd_ack_i),
	.mounted_i (img_mounted_i),
	.toggle_i  (mount_toggle_o)
);

//--- verification/atari_io_tb.sv
`include "atari_io_consts.svh"

module atari_io_tb;
	import atari_io_pkg::*;

	localparam int          TIMEOUT_CYCLES = 6000;
	localparam logic [31:0] LFSR_SEED      = 32'hb066_d320;
	localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

	logic         clk_sys;
	logic         areset;
	logic         lba_sel_i;
	logic         block_rd_i;
	logic         block_wr_i;
	unit_num_t    drv_num_i;
	lba_t         data_i;
	logic         io_wr_i;
	logic         data_wr_i;
	logic         data_rd_i;
	lba_t         data_o;
	logic         io_done_o;
	unit_mask_t   sd_rd_o;
	unit_mask_t   sd_wr_o;
	lba_t         sd_lba_o;
	unit_mask_t   sd_ack_i;
	buf_addr_t    sd_buff_addr_i;
	byte_t        sd_buff_dout_i;
	logic         sd_buff_wr_i;
	byte_t        sd_buff_din_o;
	unit_mask_t   img_mounted_i;
	logic         img_readonly_i;
	lba_t         img_size_i;
	file_type_t   file_type_i;
	logic         mount_toggle_o;
	unit_num_t    file_no_o;
	file_type_t   file_type_o;
	logic         readonly_o;
	logic         mouse_stb_i;
	mouse_delta_t mouse_dx_i;
	mouse_delta_t mouse_dy_i;
	logic [1:0]   mouse_btn_i;
	logic         invert_y_i;
	logic         cpu_halt_i;
	axis_t        stick_x_i;
	axis_t        stick_y_i;
	logic [1:0]   stick_btn_i;
	axis_t        paddle_x_o;
	axis_t        paddle_y_o;
	logic [1:0]   paddle_btn_o;
	logic         mouse_mode_o;

	logic [31:0]  lfsr_state = LFSR_SEED;
	logic         exp_toggle = 1'b0;
	int           checks = 0;
	int           errors = 0;
	int           cycles = 0;

	atari_io_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Helpers
	// ========================================================================
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// Controller strobes stay high 3 cycles and low 3 cycles
	task automatic ctl_write(input logic [31:0] value);
		data_i    = value;
		data_wr_i = 1'b1;
		repeat (3) @(negedge clk_sys);
		data_wr_i = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic ptr_reset();
		io_wr_i = 1'b1;
		repeat (3) @(negedge clk_sys);
		io_wr_i = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic ctl_read_next();
		data_rd_i = 1'b1;
		repeat (3) @(negedge clk_sys);
		data_rd_i = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic host_read(input buf_addr_t addr, output byte_t q);
		sd_buff_addr_i = addr;
		@(negedge clk_sys);
		q = sd_buff_din_o;
	endtask

	task automatic host_write(input buf_addr_t addr, input byte_t d);
		sd_buff_addr_i = addr;
		sd_buff_dout_i = d;
		sd_buff_wr_i   = 1'b1;
		@(negedge clk_sys);
		sd_buff_wr_i = 1'b0;
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic test_reset_state();
		check_value("sd_rd_o", 32'(sd_rd_o), 32'd0);
		check_value("sd_wr_o", 32'(sd_wr_o), 32'd0);
		check_value("io_done_o", 32'(io_done_o), 32'd0);
		check_value("mount_toggle_o", 32'(mount_toggle_o), 32'd0);
		check_value("mouse_mode_o", 32'(mouse_mode_o), 32'd0);
		check_value("paddle_x_o", 32'(paddle_x_o), 32'(stick_x_i));
		check_value("paddle_y_o", 32'(paddle_y_o), 32'(stick_y_i));
		check_value("paddle_btn_o", 32'(paddle_btn_o), 32'(stick_btn_i));
	endtask

	task automatic test_buffer_path();
		byte_t       sent [16];
		byte_t       q;
		logic [31:0] r;
		ptr_reset();
		for (int i = 0; i < 16; i++) begin
			rand_bits(8, r);
			sent[i] = r[7:0];
			ctl_write(r);
		end
		for (int i = 0; i < 16; i++) begin
			host_read(buf_addr_t'(i), q);
			check_value("sd_buff_din_o", 32'(q), 32'(sent[i]));
		end
		// Host fills the buffer, controller reads it back from the start
		for (int i = 0; i < 16; i++) begin
			rand_bits(8, r);
			sent[i] = r[7:0];
			host_write(buf_addr_t'(i), r[7:0]);
		end
		ptr_reset();
		for (int i = 0; i < 16; i++) begin
			check_value("data_o", data_o, 32'(sent[i]));
			ctl_read_next();
		end
	endtask

	task automatic test_block_transfer(input logic is_write, input int unit);
		logic [31:0] lba;
		unit_mask_t  mask;
		mask = unit_mask_t'(1 << unit);
		rand_bits(32, lba);
		lba_sel_i = 1'b1;
		ctl_write(lba);
		lba_sel_i = 1'b0;
		check_value("sd_lba_o", sd_lba_o, lba);
		drv_num_i = unit_num_t'(unit);
		if (is_write) begin
			block_wr_i = 1'b1;
		end else begin
			block_rd_i = 1'b1;
		end
		repeat (2) @(negedge clk_sys);
		check_value("sd_rd_o", 32'(sd_rd_o), is_write ? 32'd0 : 32'(mask));
		check_value("sd_wr_o", 32'(sd_wr_o), is_write ? 32'(mask) : 32'd0);
		check_value("io_done_o", 32'(io_done_o), 32'd0);
		repeat (2) @(negedge clk_sys);
		block_rd_i = 1'b0;
		block_wr_i = 1'b0;
		// Host holds off its acknowledge
		repeat (4) @(negedge clk_sys);
		check_value("sd_rd_o|sd_wr_o", 32'(sd_rd_o | sd_wr_o), 32'(mask));
		sd_ack_i = mask;
		repeat (3) @(negedge clk_sys);
		check_value("sd_rd_o", 32'(sd_rd_o), 32'd0);
		check_value("sd_wr_o", 32'(sd_wr_o), 32'd0);
		check_value("io_done_o", 32'(io_done_o), 32'd0);
		sd_ack_i = '0;
		while (io_done_o !== 1'b1) begin
			@(negedge clk_sys);
		end
		@(negedge clk_sys);
		check_value("io_done_o", 32'(io_done_o), 32'd1);
	endtask

	task automatic mount_image(input int unit, input logic ro);
		logic [31:0] size;
		logic [31:0] ftype;
		logic        exp_ro;
		rand_bits(32, size);
		rand_bits(2, ftype);
		exp_ro = ro || (unit == `UNIT_RO_A) || (unit == `UNIT_RO_B);
		img_mounted_i  = unit_mask_t'(1 << unit);
		img_readonly_i = ro;
		img_size_i     = size;
		file_type_i    = file_type_t'(ftype);
		@(negedge clk_sys);
		img_mounted_i  = '0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		repeat (3) @(negedge clk_sys);
		exp_toggle = ~exp_toggle;
		check_value("mount_toggle_o", 32'(mount_toggle_o), 32'(exp_toggle));
		check_value("file_no_o", 32'(file_no_o), 32'(unit));
		check_value("readonly_o", 32'(readonly_o), 32'(exp_ro));
		check_value("file_type_o", 32'(file_type_o), 32'(ftype[1:0]));
		lba_sel_i = 1'b1;
		repeat (3) @(negedge clk_sys);
		check_value("data_o", data_o, size);
		lba_sel_i = 1'b0;
	endtask

	// 15 packets of dx +50 and dy +3, y inverted, steps clamped to 10
	task automatic test_mouse();
		stick_x_i   = '0;
		stick_y_i   = '0;
		invert_y_i  = 1'b1;
		mouse_dx_i  = 9'sd50;
		mouse_dy_i  = 9'sd3;
		mouse_btn_i = 2'b10;
		stick_btn_i = 2'b01;
		for (int i = 0; i < 15; i++) begin
			mouse_stb_i = ~mouse_stb_i;
			repeat (3) @(negedge clk_sys);
		end
		check_value("mouse_mode_o", 32'(mouse_mode_o), 32'd1);
		check_value("paddle_x_o", 32'(paddle_x_o), 32'(axis_t'(127)));
		check_value("paddle_y_o", 32'(paddle_y_o), 32'(axis_t'(-45)));
		check_value("paddle_btn_o", 32'(paddle_btn_o), 32'(2'b10));
		stick_x_i = 8'sd20;
		stick_y_i = -8'sd7;
		repeat (2) @(negedge clk_sys);
		check_value("mouse_mode_o", 32'(mouse_mode_o), 32'd0);
		check_value("paddle_x_o", 32'(paddle_x_o), 32'(axis_t'(20)));
		check_value("paddle_y_o", 32'(paddle_y_o), 32'(axis_t'(-7)));
		check_value("paddle_btn_o", 32'(paddle_btn_o), 32'(2'b01));
	endtask

	// ========================================================================
	// Main sequence and timeout
	// ========================================================================
	initial begin
		areset         = 1'b1;
		lba_sel_i      = 1'b0;
		block_rd_i     = 1'b0;
		block_wr_i     = 1'b0;
		drv_num_i      = '0;
		data_i         = '0;
		io_wr_i        = 1'b0;
		data_wr_i      = 1'b0;
		data_rd_i      = 1'b0;
		sd_ack_i       = '0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		img_mounted_i  = '0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		file_type_i    = '0;
		mouse_stb_i    = 1'b0;
		mouse_dx_i     = '0;
		mouse_dy_i     = '0;
		mouse_btn_i    = 2'b00;
		invert_y_i     = 1'b0;
		cpu_halt_i     = 1'b0;
		stick_x_i      = 8'sd33;
		stick_y_i      = -8'sd12;
		stick_btn_i    = 2'b01;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		areset = 1'b0;
		@(negedge clk_sys);
		test_reset_state();
		test_buffer_path();
		test_block_transfer(1'b0, 3);
		test_block_transfer(1'b1, 3);
		mount_image(`UNIT_RO_B, 1'b0);
		mount_image(1, 1'b1);
		// A writable unit mounted read-write clears the flag
		mount_image(2, 1'b0);
		test_mouse();
		repeat (4) @(negedge clk_sys);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- build.f
+incdir+hw
hw/atari_io_pkg.sv
hw/sector_buffer.sv
hw/disk_bridge.sv
hw/mouse_axis.sv
hw/atari_io_top.sv
verification/atari_io_props.sv
verification/atari_io_tb.sv

//--- Makefile
# Verilator run of the disk and pointer I/O testbench

VERILATOR ?= verilator
TOP       ?= atari_io_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
